//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "Done: no errors" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
verilog/params_pkg.sv
verilog/csr_insn_decode.sv
verilog/trap_gen.sv
verilog/csr_regfile.sv
verilog/csr_unit.sv
verif/tb_clock_gen.sv
verif/csr_unit_tb.sv

//--- verif/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

  localparam int NUM_INSNS  = 600;
  localparam int CLK_PERIOD = 40;

  logic        clk_i;
  logic        rst_i;
  logic        valid_i;
  logic [31:0] insn_i;
  logic [31:0] pc_i;
  logic [31:0] rs1_data_i;
  logic [31:0] rd_wdata_o;
  logic [31:0] csr_rmask_o;
  logic [31:0] csr_wmask_o;
  logic [31:0] csr_wdata_o;
  logic        redirect_o;
  logic [31:0] redirect_addr_o;
  logic        trap_o;
  logic [30:0] trap_cause_o;

  // reference copies of the CSR state
  logic [31:0] m_mtvec;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic [31:0] m_mtval;
  logic [63:0] m_mcycle;
  logic [63:0] m_minstret;

  integer seed;
  int     error_count;
  int     check_count;

  tb_clock_gen clock_gen_i (
    .clk_o (clk_i)
  );

  csr_unit dut_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .valid_i         (valid_i),
    .insn_i          (insn_i),
    .pc_i            (pc_i),
    .rs1_data_i      (rs1_data_i),
    .rd_wdata_o      (rd_wdata_o),
    .csr_rmask_o     (csr_rmask_o),
    .csr_wmask_o     (csr_wmask_o),
    .csr_wdata_o     (csr_wdata_o),
    .redirect_o      (redirect_o),
    .redirect_addr_o (redirect_addr_o),
    .trap_o          (trap_o),
    .trap_cause_o    (trap_cause_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic csr_known(input logic [11:0] addr);
    return addr inside {params_pkg::CSR_ADDR_MTVEC, params_pkg::CSR_ADDR_MSCRATCH,
                        params_pkg::CSR_ADDR_MEPC, params_pkg::CSR_ADDR_MCAUSE,
                        params_pkg::CSR_ADDR_MTVAL, params_pkg::CSR_ADDR_MCYCLE,
                        params_pkg::CSR_ADDR_MCYCLEH, params_pkg::CSR_ADDR_MINSTRET,
                        params_pkg::CSR_ADDR_MINSTRETH};
  endfunction

  function automatic logic [11:0] csr_by_index(input int idx);
    case (idx)
      0:       return params_pkg::CSR_ADDR_MTVEC;
      1:       return params_pkg::CSR_ADDR_MSCRATCH;
      2:       return params_pkg::CSR_ADDR_MEPC;
      3:       return params_pkg::CSR_ADDR_MCAUSE;
      4:       return params_pkg::CSR_ADDR_MTVAL;
      5:       return params_pkg::CSR_ADDR_MCYCLE;
      6:       return params_pkg::CSR_ADDR_MCYCLEH;
      7:       return params_pkg::CSR_ADDR_MINSTRET;
      default: return params_pkg::CSR_ADDR_MINSTRETH;
    endcase
  endfunction

  // csrrw, csrrs, csrrc and their immediate forms
  function automatic logic [2:0] csr_funct3(input logic [2:0] sel);
    case (sel)
      3'd0:    return 3'b001;
      3'd1:    return 3'b010;
      3'd2:    return 3'b011;
      3'd3:    return 3'b101;
      3'd4:    return 3'b110;
      default: return 3'b111;
    endcase
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] addr);
    case (addr)
      params_pkg::CSR_ADDR_MTVEC:     return m_mtvec;
      params_pkg::CSR_ADDR_MSCRATCH:  return m_mscratch;
      params_pkg::CSR_ADDR_MEPC:      return m_mepc;
      params_pkg::CSR_ADDR_MCAUSE:    return m_mcause;
      params_pkg::CSR_ADDR_MTVAL:     return m_mtval;
      params_pkg::CSR_ADDR_MCYCLE:    return m_mcycle[31:0];
      params_pkg::CSR_ADDR_MCYCLEH:   return m_mcycle[63:32];
      params_pkg::CSR_ADDR_MINSTRET:  return m_minstret[31:0];
      params_pkg::CSR_ADDR_MINSTRETH: return m_minstret[63:32];
      default:                        return 32'h0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_cause(input string name, input logic [30:0] got,
                             input logic [30:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic drive_next(input int idx);
    logic [31:0] rnd;
    logic [31:0] rnd2;
    logic [2:0]  f3;
    logic [11:0] addr;
    logic [4:0]  rs1f;
    logic [4:0]  rdf;
    int          kind;

    kind = int'($unsigned($random(seed)) % 100);
    rnd  = $random(seed);
    rnd2 = $random(seed);
    // x0 as rs1 or rd shows up about a quarter and an eighth of the time
    rs1f = (rnd[1:0] == 2'b00) ? 5'd0 : rnd[6:2];
    rdf  = (rnd[10:8] == 3'b000) ? 5'd0 : rnd[15:11];
    f3   = csr_funct3(rnd[18:16]);
    addr = csr_by_index(int'(rnd[22:19]) % 9);

    valid_i    <= 1'b1;
    pc_i       <= 32'h8000_0000 + (idx << 2);
    rs1_data_i <= $random(seed);

    if (kind < 10) begin
      // idle slot with a SYSTEM word on the bus, which must be ignored
      valid_i <= 1'b0;
      if (rnd2[0]) begin
        insn_i <= {addr, rs1f, f3, rdf, params_pkg::OPCODE_SYSTEM};
      end else begin
        insn_i <= {rnd2[31:7], params_pkg::OPCODE_SYSTEM};
      end
    end else if (kind < 60) begin
      insn_i <= {addr, rs1f, f3, rdf, params_pkg::OPCODE_SYSTEM};
    end else if (kind < 65) begin
      // unimplemented address, sometimes with the reserved funct3
      if (rnd2[1:0] == 2'b11) begin
        f3 = 3'b100;
      end
      insn_i <= {rnd2[31:20], rs1f, f3, rdf, params_pkg::OPCODE_SYSTEM};
    end else if (kind < 70) begin
      insn_i <= {params_pkg::FUNCT12_ECALL, 13'd0, params_pkg::OPCODE_SYSTEM};
    end else if (kind < 74) begin
      insn_i <= {params_pkg::FUNCT12_EBREAK, 13'd0, params_pkg::OPCODE_SYSTEM};
    end else if (kind < 80) begin
      insn_i <= {params_pkg::FUNCT12_MRET, 13'd0, params_pkg::OPCODE_SYSTEM};
    end else if (kind < 85) begin
      // unknown privileged function, top bit set keeps it off the known ones
      insn_i <= {1'b1, rnd2[30:20], 13'd0, params_pkg::OPCODE_SYSTEM};
    end else begin
      if (rnd2[6:0] == params_pkg::OPCODE_SYSTEM) begin
        rnd2[4] = 1'b0;
      end
      insn_i <= rnd2;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // expected results and model update, once per cycle
  //////////////////////////////////////////////////////////////////////

  task automatic check_and_update();
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [4:0]  rs1f;
    logic [4:0]  rdf;
    logic [11:0] f12;
    logic        exp_trap;
    logic        exp_redirect;
    logic        is_csr;
    logic        do_write;
    logic [30:0] exp_cause;
    logic [31:0] exp_tval;
    logic [31:0] exp_target;
    logic [31:0] old_val;
    logic [31:0] operand;
    logic [31:0] new_val;

    opcode       = insn_i[6:0];
    rdf          = insn_i[11:7];
    f3           = insn_i[14:12];
    rs1f         = insn_i[19:15];
    f12          = insn_i[31:20];
    exp_trap     = 1'b0;
    exp_redirect = 1'b0;
    is_csr       = 1'b0;
    do_write     = 1'b0;
    exp_cause    = '0;
    exp_tval     = '0;
    exp_target   = '0;
    new_val      = '0;
    old_val      = model_read(f12);
    operand      = f3[2] ? {27'd0, rs1f} : rs1_data_i;

    if (valid_i && (opcode == params_pkg::OPCODE_SYSTEM)) begin
      if (f3 == 3'b000) begin
        if (f12 == params_pkg::FUNCT12_ECALL) begin
          exp_trap  = 1'b1;
          exp_cause = params_pkg::CAUSE_ECALL_M;
        end else if (f12 == params_pkg::FUNCT12_EBREAK) begin
          exp_trap  = 1'b1;
          exp_cause = params_pkg::CAUSE_BREAKPOINT;
        end else if (f12 == params_pkg::FUNCT12_MRET) begin
          exp_redirect = 1'b1;
          exp_target   = m_mepc;
        end else begin
          exp_trap  = 1'b1;
          exp_cause = params_pkg::CAUSE_ILLEGAL_INSN;
          exp_tval  = insn_i;
        end
      end else if ((f3 == 3'b100) || !csr_known(f12)) begin
        exp_trap  = 1'b1;
        exp_cause = params_pkg::CAUSE_ILLEGAL_INSN;
        exp_tval  = insn_i;
      end else begin
        is_csr   = 1'b1;
        // set and clear with a zero source only read
        do_write = (f3[1:0] == 2'b01) || (rs1f != 5'd0);
        case (f3[1:0])
          2'b01:   new_val = operand;
          2'b10:   new_val = old_val | operand;
          default: new_val = old_val & ~operand;
        endcase
      end
    end

    if (exp_trap) begin
      exp_redirect = 1'b1;
      exp_target   = {m_mtvec[31:2], 2'b00};
    end

    check_bit("trap_o", trap_o, exp_trap);
    check_bit("redirect_o", redirect_o, exp_redirect);
    if (exp_redirect) begin
      check_word("redirect_addr_o", redirect_addr_o, exp_target);
    end
    if (exp_trap) begin
      check_cause("trap_cause_o", trap_cause_o, exp_cause);
    end
    check_word("csr_rmask_o", csr_rmask_o,
               (is_csr && (rdf != 5'd0)) ? 32'hffff_ffff : 32'h0);
    check_word("csr_wmask_o", csr_wmask_o, do_write ? 32'hffff_ffff : 32'h0);
    if (is_csr && (rdf != 5'd0)) begin
      check_word("rd_wdata_o", rd_wdata_o, old_val);
    end
    if (do_write) begin
      check_word("csr_wdata_o", csr_wdata_o, new_val);
    end

    if (exp_trap) begin
      m_mepc   = pc_i;
      m_mcause = {1'b0, exp_cause};
      m_mtval  = exp_tval;
    end else if (do_write) begin
      case (f12)
        params_pkg::CSR_ADDR_MTVEC:    m_mtvec    = {new_val[31:2], 2'b00};
        params_pkg::CSR_ADDR_MSCRATCH: m_mscratch = new_val;
        params_pkg::CSR_ADDR_MEPC:     m_mepc     = new_val;
        params_pkg::CSR_ADDR_MCAUSE:   m_mcause   = new_val;
        params_pkg::CSR_ADDR_MTVAL:    m_mtval    = new_val;
        // counters keep counting
        default: ;
      endcase
    end
    m_mcycle = m_mcycle + 64'd1;
    if (valid_i && !exp_trap) begin
      m_minstret = m_minstret + 64'd1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed        = 32'h9dca349e;
    error_count = 0;
    check_count = 0;
    rst_i       = 1'b1;
    valid_i     = 1'b0;
    insn_i      = 32'h0;
    pc_i        = 32'h0;
    rs1_data_i  = 32'h0;
    m_mtvec     = 32'h0;
    m_mscratch  = 32'h0;
    m_mepc      = 32'h0;
    m_mcause    = 32'h0;
    m_mtval     = 32'h0;
    m_mcycle    = 64'h0;
    m_minstret  = 64'h0;

    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;

    // inputs change on the rising edge, outputs are sampled on the falling edge
    for (int n = 0; n < NUM_INSNS; n++) begin
      drive_next(n);
      @(negedge clk_i);
      check_and_update();
      @(posedge clk_i);
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #((NUM_INSNS + 20) * CLK_PERIOD);
    $display("timeout: the instruction stream did not finish in %0d cycles",
             NUM_INSNS + 20);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  // 40 ns period
  localparam int HALF_PERIOD = 20;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

//--- verilog/csr_insn_decode.sv
`timescale 1ns/1ps

module csr_insn_decode (
  input  logic        valid_i,
  input  logic [31:0] insn_i,
  input  logic [31:0] rs1_data_i,
  output logic [11:0] csr_addr_o,
  output logic [1:0]  csr_wtype_o,
  output logic [31:0] csr_woperand_o,
  output logic [4:0]  rd_addr_o,
  output logic        is_ecall_o,
  output logic        is_ebreak_o,
  output logic        is_mret_o,
  output logic        is_illegal_o
);

  // I-type fields of the SYSTEM word
  logic [6:0]  opcode;
  logic [4:0]  rd_field;
  logic [2:0]  funct3;
  logic [4:0]  rs1_field;
  logic [11:0] funct12;
  logic        is_system;
  logic        addr_known;

  assign opcode    = insn_i[6:0];
  assign rd_field  = insn_i[11:7];
  assign funct3    = insn_i[14:12];
  assign rs1_field = insn_i[19:15];
  assign funct12   = insn_i[31:20];

  assign is_system = valid_i && (opcode == params_pkg::OPCODE_SYSTEM);

  // CSR addresses backed by storage in the register file
  always_comb begin
    case (funct12)
      params_pkg::CSR_ADDR_MTVEC,
      params_pkg::CSR_ADDR_MSCRATCH,
      params_pkg::CSR_ADDR_MEPC,
      params_pkg::CSR_ADDR_MCAUSE,
      params_pkg::CSR_ADDR_MTVAL,
      params_pkg::CSR_ADDR_MCYCLE,
      params_pkg::CSR_ADDR_MCYCLEH,
      params_pkg::CSR_ADDR_MINSTRET,
      params_pkg::CSR_ADDR_MINSTRETH: addr_known = 1'b1;
      default:                        addr_known = 1'b0;
    endcase
  end

  always_comb begin
    csr_addr_o     = '0;
    csr_wtype_o    = params_pkg::CSR_WRITE_NONE;
    csr_woperand_o = '0;
    rd_addr_o      = '0;
    is_ecall_o     = 1'b0;
    is_ebreak_o    = 1'b0;
    is_mret_o      = 1'b0;
    is_illegal_o   = 1'b0;

    if (is_system) begin
      case (funct3)
        // privileged group, told apart by the upper field
        3'b000: begin
          case (funct12)
            params_pkg::FUNCT12_ECALL:  is_ecall_o   = 1'b1;
            params_pkg::FUNCT12_EBREAK: is_ebreak_o  = 1'b1;
            params_pkg::FUNCT12_MRET:   is_mret_o    = 1'b1;
            default:                    is_illegal_o = 1'b1;
          endcase
        end
        3'b100: is_illegal_o = 1'b1;
        default: begin
          if (!addr_known) begin
            is_illegal_o = 1'b1;
          end else begin
            csr_addr_o     = funct12;
            rd_addr_o      = rd_field;
            // funct3[2] selects the zero-extended uimm form
            csr_woperand_o = funct3[2] ? {27'd0, rs1_field} : rs1_data_i;
            // set or clear with x0 or uimm 0 is a pure read
            if ((funct3[1:0] != params_pkg::CSR_WRITE_RAW_VALUE) && (rs1_field == 5'd0)) begin
              csr_wtype_o = params_pkg::CSR_WRITE_NONE;
            end else begin
              csr_wtype_o = funct3[1:0];
            end
          end
        end
      endcase
    end

    // the four kinds exclude each other for any word
    assert ($onehot0({is_ecall_o, is_ebreak_o, is_mret_o, is_illegal_o}))
      else $error("csr_insn_decode: more than one of ecall/ebreak/mret/illegal");
  end

endmodule

//--- verilog/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        valid_i,
  input  logic [11:0] csr_addr_i,
  input  logic [1:0]  csr_wtype_i,
  input  logic [31:0] csr_woperand_i,
  input  logic [4:0]  rd_addr_i,
  input  logic        trap_valid_i,
  input  logic [30:0] trap_cause_i,
  input  logic [31:0] trap_tval_i,
  input  logic [31:0] trap_pc_i,
  output logic [31:0] mtvec_o,
  output logic [31:0] mepc_o,
  output logic [31:0] csr_rdata_o,
  output logic [31:0] csr_wdata_o,
  output logic [31:0] csr_rmask_o,
  output logic [31:0] csr_wmask_o
);

  logic [31:0] mtvec_q;
  logic [31:0] mscratch_q;
  logic [31:0] mepc_q;
  logic [31:0] mcause_q;
  logic [31:0] mtval_q;
  logic [63:0] mcycle_q;
  logic [63:0] minstret_q;
  logic [31:0] rdata;
  logic [31:0] wdata;
  logic        write_en;
  logic        take_trap;

  //////////////////////////////////////////////////////////////////////
  // read mux and read-modify-write
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (csr_addr_i)
      params_pkg::CSR_ADDR_MTVEC:     rdata = mtvec_q;
      params_pkg::CSR_ADDR_MSCRATCH:  rdata = mscratch_q;
      params_pkg::CSR_ADDR_MEPC:      rdata = mepc_q;
      params_pkg::CSR_ADDR_MCAUSE:    rdata = mcause_q;
      params_pkg::CSR_ADDR_MTVAL:     rdata = mtval_q;
      params_pkg::CSR_ADDR_MCYCLE:    rdata = mcycle_q[31:0];
      params_pkg::CSR_ADDR_MCYCLEH:   rdata = mcycle_q[63:32];
      params_pkg::CSR_ADDR_MINSTRET:  rdata = minstret_q[31:0];
      params_pkg::CSR_ADDR_MINSTRETH: rdata = minstret_q[63:32];
      default:                        rdata = '0;
    endcase

    case (csr_wtype_i)
      params_pkg::CSR_WRITE_RAW_VALUE:      wdata = csr_woperand_i;
      params_pkg::CSR_WRITE_SET_BIT_MASK:   wdata = rdata | csr_woperand_i;
      params_pkg::CSR_WRITE_CLEAR_BIT_MASK: wdata = rdata & ~csr_woperand_i;
      default:                              wdata = rdata;
    endcase
  end

  assign take_trap = valid_i && trap_valid_i;
  assign write_en  = valid_i && !trap_valid_i && (csr_wtype_i != params_pkg::CSR_WRITE_NONE);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // trap capture wins over any CSR write in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else if (take_trap) begin
      mepc_q   <= trap_pc_i;
      mcause_q <= {1'b0, trap_cause_i};
      mtval_q  <= trap_tval_i;
    end else if (write_en) begin
      case (csr_addr_i)
        params_pkg::CSR_ADDR_MTVEC:    mtvec_q    <= {wdata[31:2], 2'b00};
        params_pkg::CSR_ADDR_MSCRATCH: mscratch_q <= wdata;
        params_pkg::CSR_ADDR_MEPC:     mepc_q     <= wdata;
        params_pkg::CSR_ADDR_MCAUSE:   mcause_q   <= wdata;
        params_pkg::CSR_ADDR_MTVAL:    mtval_q    <= wdata;
        // counter addresses only count, writes to them are dropped
        default: ;
      endcase
    end
  end

  // free-running cycle count and retired-instruction count
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q   <= '0;
      minstret_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
      if (valid_i && !trap_valid_i) begin
        minstret_q <= minstret_q + 64'd1;
      end
    end
  end

  assign mtvec_o     = mtvec_q;
  assign mepc_o      = mepc_q;
  assign csr_rdata_o = rdata;
  assign csr_wdata_o = wdata;

  // retirement trace masks
  assign csr_rmask_o = (rd_addr_i != 5'd0) ? 32'hffff_ffff : 32'h0;
  assign csr_wmask_o = write_en ? 32'hffff_ffff : 32'h0;

  mtvec_aligned_a: assert property (@(posedge clk_i) disable iff (rst_i) mtvec_q[1:0] == 2'b00)
    else $error("csr_regfile: mtvec low bits not zero");

endmodule

//--- verilog/csr_unit.sv
`timescale 1ns/1ps

module csr_unit (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        valid_i,
  input  logic [31:0] insn_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] rs1_data_i,
  output logic [31:0] rd_wdata_o,
  output logic [31:0] csr_rmask_o,
  output logic [31:0] csr_wmask_o,
  output logic [31:0] csr_wdata_o,
  output logic        redirect_o,
  output logic [31:0] redirect_addr_o,
  output logic        trap_o,
  output logic [30:0] trap_cause_o
);

  // decoder results
  logic [11:0] csr_addr;
  logic [1:0]  csr_wtype;
  logic [31:0] csr_woperand;
  logic [4:0]  rd_addr;
  logic        is_ecall;
  logic        is_ebreak;
  logic        is_mret;
  logic        is_illegal;

  // trap and CSR state exchange
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] trap_tval;
  logic [31:0] trap_pc;

  csr_insn_decode decode_i (
    .valid_i        (valid_i),
    .insn_i         (insn_i),
    .rs1_data_i     (rs1_data_i),
    .csr_addr_o     (csr_addr),
    .csr_wtype_o    (csr_wtype),
    .csr_woperand_o (csr_woperand),
    .rd_addr_o      (rd_addr),
    .is_ecall_o     (is_ecall),
    .is_ebreak_o    (is_ebreak),
    .is_mret_o      (is_mret),
    .is_illegal_o   (is_illegal)
  );

  trap_gen trap_gen_i (
    .valid_i         (valid_i),
    .insn_i          (insn_i),
    .pc_i            (pc_i),
    .is_ecall_i      (is_ecall),
    .is_ebreak_i     (is_ebreak),
    .is_mret_i       (is_mret),
    .is_illegal_i    (is_illegal),
    .mtvec_i         (mtvec),
    .mepc_i          (mepc),
    .trap_valid_o    (trap_o),
    .trap_cause_o    (trap_cause_o),
    .trap_tval_o     (trap_tval),
    .trap_pc_o       (trap_pc),
    .redirect_o      (redirect_o),
    .redirect_addr_o (redirect_addr_o)
  );

  csr_regfile regfile_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (valid_i),
    .csr_addr_i     (csr_addr),
    .csr_wtype_i    (csr_wtype),
    .csr_woperand_i (csr_woperand),
    .rd_addr_i      (rd_addr),
    .trap_valid_i   (trap_o),
    .trap_cause_i   (trap_cause_o),
    .trap_tval_i    (trap_tval),
    .trap_pc_i      (trap_pc),
    .mtvec_o        (mtvec),
    .mepc_o         (mepc),
    .csr_rdata_o    (rd_wdata_o),
    .csr_wdata_o    (csr_wdata_o),
    .csr_rmask_o    (csr_rmask_o),
    .csr_wmask_o    (csr_wmask_o)
  );

endmodule

//--- verilog/params_pkg.sv
package params_pkg;

  //////////////////////////////////////////////////////////////////////
  // machine-mode CSR addresses
  //////////////////////////////////////////////////////////////////////

  // trap setup and handling
  localparam logic [11:0] CSR_ADDR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_ADDR_MSCRATCH  = 12'h340;
  localparam logic [11:0] CSR_ADDR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_ADDR_MCAUSE    = 12'h342;
  localparam logic [11:0] CSR_ADDR_MTVAL     = 12'h343;

  // 64-bit counters, split into low and high halves
  localparam logic [11:0] CSR_ADDR_MCYCLE    = 12'hB00;
  localparam logic [11:0] CSR_ADDR_MCYCLEH   = 12'hB80;
  localparam logic [11:0] CSR_ADDR_MINSTRET  = 12'hB02;
  localparam logic [11:0] CSR_ADDR_MINSTRETH = 12'hB82;

  //////////////////////////////////////////////////////////////////////
  // CSR write types
  //////////////////////////////////////////////////////////////////////

  // encoded as the low two bits of funct3 for the Zicsr group
  // csrrw/csrrwi -> raw, csrrs/csrrsi -> set, csrrc/csrrci -> clear
  localparam logic [1:0] CSR_WRITE_NONE           = 2'd0;
  localparam logic [1:0] CSR_WRITE_RAW_VALUE      = 2'd1;
  localparam logic [1:0] CSR_WRITE_SET_BIT_MASK   = 2'd2;
  localparam logic [1:0] CSR_WRITE_CLEAR_BIT_MASK = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // exception codes
  //////////////////////////////////////////////////////////////////////

  // mcause bit 31 is the interrupt flag, always clear here
  localparam logic [30:0] CAUSE_ILLEGAL_INSN = 31'd2;
  localparam logic [30:0] CAUSE_BREAKPOINT   = 31'd3;
  localparam logic [30:0] CAUSE_ECALL_M      = 31'd11;

  //////////////////////////////////////////////////////////////////////
  // instruction fields
  //////////////////////////////////////////////////////////////////////

  // major opcode shared by the CSR group and the privileged group
  localparam logic [6:0] OPCODE_SYSTEM = 7'b111_0011;

  // upper I-type field when funct3 is zero
  localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
  localparam logic [11:0] FUNCT12_MRET   = 12'h302;

endpackage

//--- verilog/trap_gen.sv
`timescale 1ns/1ps

module trap_gen (
  input  logic        valid_i,
  input  logic [31:0] insn_i,
  input  logic [31:0] pc_i,
  input  logic        is_ecall_i,
  input  logic        is_ebreak_i,
  input  logic        is_mret_i,
  input  logic        is_illegal_i,
  input  logic [31:0] mtvec_i,
  input  logic [31:0] mepc_i,
  output logic        trap_valid_o,
  output logic [30:0] trap_cause_o,
  output logic [31:0] trap_tval_o,
  output logic [31:0] trap_pc_o,
  output logic        redirect_o,
  output logic [31:0] redirect_addr_o
);

  // mepc always takes the pc of the trapping instruction
  assign trap_pc_o = pc_i;

  always_comb begin
    trap_valid_o    = valid_i && (is_ecall_i || is_ebreak_i || is_illegal_i);
    trap_cause_o    = '0;
    trap_tval_o     = '0;
    redirect_o      = 1'b0;
    redirect_addr_o = '0;

    // illegal carries the faulting word, the others report zero
    if (is_illegal_i) begin
      trap_cause_o = params_pkg::CAUSE_ILLEGAL_INSN;
      trap_tval_o  = insn_i;
    end else if (is_ebreak_i) begin
      trap_cause_o = params_pkg::CAUSE_BREAKPOINT;
    end else if (is_ecall_i) begin
      trap_cause_o = params_pkg::CAUSE_ECALL_M;
    end

    // direct mode only, so the handler base is mtvec itself
    if (trap_valid_o) begin
      redirect_o      = 1'b1;
      redirect_addr_o = {mtvec_i[31:2], 2'b00};
    end else if (valid_i && is_mret_i) begin
      redirect_o      = 1'b1;
      redirect_addr_o = mepc_i;
    end

    assert (!redirect_o || valid_i)
      else $error("trap_gen: redirect without a retiring instruction");
  end

endmodule
